//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_axi_to_reqrsp
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/axi_reqrsp_pkg.sv
// ***************************************************************************
// AXI to reqrsp shared types
// ***************************************************************************
package axi_reqrsp_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  // Burst length minus one.
  typedef logic [7:0]           len_t;
  // Log2 of the beat size in bytes.
  typedef logic [2:0]           size_t;
  typedef logic [3:0]           qos_t;
  typedef logic [1:0]           resp_t;

  localparam resp_t RespOkay   = 2'd0;
  localparam resp_t RespSlvErr = 2'd2;

  // Address channel, shared by AR and AW.
  typedef struct packed {
    addr_t addr;
    id_t   id;
    len_t  len;
    size_t size;
    qos_t  qos;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
    resp_t resp;
  } r_chan_t;

  // One single-beat memory access and what is needed to answer it.
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
    size_t size;
    qos_t  qos;
    logic  write;
  } beat_meta_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t data;
    strb_t strb;
    size_t size;
  } mem_req_t;

  typedef struct packed {
    data_t data;
    logic  error;
  } mem_rsp_t;

  // Bytes covered by one beat of the given size.
  function automatic addr_t beat_bytes(size_t size);
    return addr_t'(1) << size;
  endfunction

  // Address rounded down to a multiple of the beat size.
  function automatic addr_t align_addr(addr_t addr, size_t size);
    return addr & ~(beat_bytes(size) - addr_t'(1));
  endfunction

endpackage

//--- hw/axi_to_reqrsp.sv
// ***************************************************************************
// AXI to reqrsp bridge
// ***************************************************************************
`timescale 1ns/1ps

module axi_to_reqrsp #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  output logic                     busy_o,
  input  axi_reqrsp_pkg::ax_chan_t ar_i,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  axi_reqrsp_pkg::ax_chan_t aw_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  axi_reqrsp_pkg::w_chan_t  w_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  output axi_reqrsp_pkg::r_chan_t  r_o,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output axi_reqrsp_pkg::b_chan_t  b_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output axi_reqrsp_pkg::mem_req_t mem_req_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  input  axi_reqrsp_pkg::mem_rsp_t mem_rsp_i,
  input  logic                     mem_rsp_valid_i,
  output logic                     mem_rsp_ready_o
);

  import axi_reqrsp_pkg::*;

  beat_meta_t rd_beat, wr_beat, arb_beat, meta_in, meta_out;
  w_chan_t    w_beat;
  logic       rd_valid, rd_ready, rd_in_burst;
  logic       wr_valid, wr_ready, wr_in_burst;
  logic       arb_valid, arb_ready, write_sel;
  logic       meta_in_valid, meta_in_ready;
  logic       meta_out_valid, meta_out_ready;

  assign busy_o = ar_valid_i || aw_valid_i || w_valid_i || r_valid_o || b_valid_o ||
                  rd_in_burst || wr_in_burst;

  rd_burst_seq i_rd_seq (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ar_i         (ar_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .beat_o       (rd_beat),
    .beat_valid_o (rd_valid),
    .beat_ready_i (rd_ready),
    .in_burst_o   (rd_in_burst)
  );

  wr_burst_seq i_wr_seq (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .aw_i         (aw_i),
    .aw_valid_i   (aw_valid_i),
    .aw_ready_o   (aw_ready_o),
    .w_i          (w_i),
    .w_valid_i    (w_valid_i),
    .w_ready_o    (w_ready_o),
    .beat_o       (wr_beat),
    .w_beat_o     (w_beat),
    .beat_valid_o (wr_valid),
    .beat_ready_i (wr_ready),
    .in_burst_o   (wr_in_burst)
  );

  rw_arbiter i_arb (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rd_beat_i     (rd_beat),
    .rd_valid_i    (rd_valid),
    .rd_ready_o    (rd_ready),
    .rd_in_burst_i (rd_in_burst),
    .wr_beat_i     (wr_beat),
    .wr_valid_i    (wr_valid),
    .wr_ready_o    (wr_ready),
    .wr_in_burst_i (wr_in_burst),
    .beat_o        (arb_beat),
    .write_sel_o   (write_sel),
    .beat_valid_o  (arb_valid),
    .beat_ready_i  (arb_ready)
  );

  req_issue #(
    .BufDepth (BufDepth)
  ) i_issue (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .beat_i          (arb_beat),
    .w_beat_i        (w_beat),
    .write_sel_i     (write_sel),
    .beat_valid_i    (arb_valid),
    .beat_ready_o    (arb_ready),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .meta_o          (meta_in),
    .meta_valid_o    (meta_in_valid),
    .meta_ready_i    (meta_in_ready)
  );

  // One slot more than the response latency keeps the request path streaming.
  meta_fifo #(
    .Depth (BufDepth + 1)
  ) i_meta_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (meta_in),
    .valid_i (meta_in_valid),
    .ready_o (meta_in_ready),
    .data_o  (meta_out),
    .valid_o (meta_out_valid),
    .ready_i (meta_out_ready)
  );

  rsp_router i_router (
    .meta_i          (meta_out),
    .meta_valid_i    (meta_out_valid),
    .meta_ready_o    (meta_out_ready),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .r_o             (r_o),
    .r_valid_o       (r_valid_o),
    .r_ready_i       (r_ready_i),
    .b_o             (b_o),
    .b_valid_o       (b_valid_o),
    .b_ready_i       (b_ready_i)
  );

endmodule

//--- hw/meta_fifo.sv
// ***************************************************************************
// Outstanding request FIFO
// ***************************************************************************
`timescale 1ns/1ps

module meta_fifo #(
  parameter int unsigned Depth = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  axi_reqrsp_pkg::beat_meta_t data_i,
  input  logic                       valid_i,
  output logic                       ready_o,
  output axi_reqrsp_pkg::beat_meta_t data_o,
  output logic                       valid_o,
  input  logic                       ready_i
);

  import axi_reqrsp_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  beat_meta_t mem_q [Depth];
  ptr_t       wr_ptr_q, rd_ptr_q;
  cnt_t       cnt_q;
  logic       empty, push, pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign empty   = (cnt_q == '0);
  assign ready_o = (cnt_q != cnt_t'(Depth));
  assign valid_o = !empty || valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];
  // An entry that is taken in the cycle it arrives never gets stored.
  assign push    = valid_i && ready_o && !(empty && ready_i);
  assign pop     = ready_i && !empty;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- hw/rd_burst_seq.sv
// ***************************************************************************
// Read burst sequencer
// ***************************************************************************
`timescale 1ns/1ps

module rd_burst_seq (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  axi_reqrsp_pkg::ax_chan_t   ar_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  output axi_reqrsp_pkg::beat_meta_t beat_o,
  output logic                       beat_valid_o,
  input  logic                       beat_ready_i,
  output logic                       in_burst_o
);

  import axi_reqrsp_pkg::*;

  len_t       cnt_d, cnt_q;
  beat_meta_t meta_d, meta_q;

  assign in_burst_o = (cnt_q != '0);

  always_comb begin
    ar_ready_o   = 1'b0;
    beat_o       = '0;
    beat_valid_o = 1'b0;
    cnt_d        = cnt_q;
    meta_d       = meta_q;
    if (in_burst_o) begin
      // Remaining beats step from the aligned address of the previous one.
      beat_o       = meta_q;
      beat_o.addr  = meta_q.addr + beat_bytes(meta_q.size);
      beat_o.last  = (cnt_q == len_t'(1));
      beat_valid_o = 1'b1;
      if (beat_ready_i) begin
        cnt_d       = cnt_q - len_t'(1);
        meta_d.addr = beat_o.addr;
      end
    end else if (ar_valid_i) begin
      meta_d = '{
        addr:  align_addr(ar_i.addr, ar_i.size),
        id:    ar_i.id,
        last:  (ar_i.len == '0),
        size:  ar_i.size,
        qos:   ar_i.qos,
        write: 1'b0
      };
      // The first beat goes out with the unaligned address.
      beat_o       = meta_d;
      beat_o.addr  = ar_i.addr;
      beat_valid_o = 1'b1;
      if (beat_ready_i) begin
        cnt_d      = ar_i.len;
        ar_ready_o = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    meta_q <= meta_d;
  end

endmodule

//--- hw/req_issue.sv
// ***************************************************************************
// Memory request issue and fork
// ***************************************************************************
`timescale 1ns/1ps

module req_issue #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  axi_reqrsp_pkg::beat_meta_t beat_i,
  input  axi_reqrsp_pkg::w_chan_t    w_beat_i,
  input  logic                       write_sel_i,
  input  logic                       beat_valid_i,
  output logic                       beat_ready_o,
  output axi_reqrsp_pkg::mem_req_t   mem_req_o,
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output axi_reqrsp_pkg::beat_meta_t meta_o,
  output logic                       meta_valid_o,
  input  logic                       meta_ready_i
);

  // A response needs at least one metadata slot behind the one in flight.
  if (BufDepth == 0) begin : gen_depth_check
    $error("BufDepth must be at least one.");
  end

  // Set once a side has taken the current beat.
  logic mem_done_q, meta_done_q;
  logic mem_ok, meta_ok;

  // Reads carry no W beat, so data and strobe stay zero.
  assign mem_req_o.addr  = beat_i.addr;
  assign mem_req_o.write = beat_i.write;
  assign mem_req_o.data  = write_sel_i ? w_beat_i.data : '0;
  assign mem_req_o.strb  = write_sel_i ? w_beat_i.strb : '0;
  assign mem_req_o.size  = beat_i.size;

  assign meta_o = beat_i;

  assign mem_req_valid_o = beat_valid_i && !mem_done_q;
  assign meta_valid_o    = beat_valid_i && !meta_done_q;
  assign mem_ok          = mem_done_q || mem_req_ready_i;
  assign meta_ok         = meta_done_q || meta_ready_i;
  assign beat_ready_o    = mem_ok && meta_ok;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_done_q  <= 1'b0;
      meta_done_q <= 1'b0;
    end else if (beat_valid_i && beat_ready_o) begin
      mem_done_q  <= 1'b0;
      meta_done_q <= 1'b0;
    end else begin
      if (mem_req_valid_o && mem_req_ready_i) begin
        mem_done_q <= 1'b1;
      end
      if (meta_valid_o && meta_ready_i) begin
        meta_done_q <= 1'b1;
      end
    end
  end

endmodule

//--- hw/rsp_router.sv
// ***************************************************************************
// Memory response router
// ***************************************************************************
`timescale 1ns/1ps

module rsp_router (
  input  axi_reqrsp_pkg::beat_meta_t meta_i,
  input  logic                       meta_valid_i,
  output logic                       meta_ready_o,
  input  axi_reqrsp_pkg::mem_rsp_t   mem_rsp_i,
  input  logic                       mem_rsp_valid_i,
  output logic                       mem_rsp_ready_o,
  output axi_reqrsp_pkg::r_chan_t    r_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output axi_reqrsp_pkg::b_chan_t    b_o,
  output logic                       b_valid_o,
  input  logic                       b_ready_i
);

  import axi_reqrsp_pkg::*;

  resp_t resp;
  logic  to_r, to_b;
  logic  joined, tgt_ready;

  // Non-last write beats have no AXI response and are dropped.
  assign to_r      = !meta_i.write;
  assign to_b      = meta_i.write && meta_i.last;
  assign tgt_ready = to_r ? r_ready_i : (to_b ? b_ready_i : 1'b1);

  assign joined          = meta_valid_i && mem_rsp_valid_i;
  assign mem_rsp_ready_o = joined && tgt_ready;
  assign meta_ready_o    = joined && tgt_ready;
  assign r_valid_o       = joined && to_r;
  assign b_valid_o       = joined && to_b;

  assign resp = mem_rsp_i.error ? RespSlvErr : RespOkay;

  assign r_o = '{
    data: mem_rsp_i.data,
    id:   meta_i.id,
    last: meta_i.last,
    resp: resp
  };

  assign b_o = '{
    id:   meta_i.id,
    resp: resp
  };

endmodule

//--- hw/rw_arbiter.sv
// ***************************************************************************
// Read/write beat arbiter
// ***************************************************************************
`timescale 1ns/1ps

module rw_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  axi_reqrsp_pkg::beat_meta_t rd_beat_i,
  input  logic                       rd_valid_i,
  output logic                       rd_ready_o,
  input  logic                       rd_in_burst_i,
  input  axi_reqrsp_pkg::beat_meta_t wr_beat_i,
  input  logic                       wr_valid_i,
  output logic                       wr_ready_o,
  input  logic                       wr_in_burst_i,
  output axi_reqrsp_pkg::beat_meta_t beat_o,
  output logic                       write_sel_o,
  output logic                       beat_valid_o,
  input  logic                       beat_ready_i
);

  // High selects the write side.
  logic sel_d, sel_q;
  logic lock_d, lock_q;

  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (wr_valid_i ^ rd_valid_i) begin
        sel_d = wr_valid_i;
      end else if (wr_valid_i && rd_valid_i) begin
        if (wr_beat_i.qos != rd_beat_i.qos) begin
          sel_d = (wr_beat_i.qos > rd_beat_i.qos);
        // Write bursts cannot interleave, so a lone write goes before a read burst.
        end else if (wr_beat_i.last && !rd_beat_i.last) begin
          sel_d = 1'b1;
        end else if (wr_in_burst_i) begin
          sel_d = 1'b1;
        end else if (rd_in_burst_i) begin
          sel_d = 1'b0;
        end else begin
          sel_d = ~sel_q;
        end
      end
    end
  end

  // Hold the choice while the chosen beat is stalled.
  always_comb begin
    lock_d = lock_q;
    if (lock_q) begin
      if (beat_valid_o && beat_ready_i) begin
        lock_d = 1'b0;
      end
    end else if (beat_valid_o && !beat_ready_i) begin
      lock_d = 1'b1;
    end
  end

  assign write_sel_o  = sel_d;
  assign beat_o       = sel_d ? wr_beat_i : rd_beat_i;
  assign beat_valid_o = sel_d ? wr_valid_i : rd_valid_i;
  assign rd_ready_o   = !sel_d && beat_ready_i;
  assign wr_ready_o   = sel_d && beat_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= lock_d;
    end
  end

endmodule

//--- hw/wr_burst_seq.sv
// ***************************************************************************
// Write burst sequencer
// ***************************************************************************
`timescale 1ns/1ps

module wr_burst_seq (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  axi_reqrsp_pkg::ax_chan_t   aw_i,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  axi_reqrsp_pkg::w_chan_t    w_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  output axi_reqrsp_pkg::beat_meta_t beat_o,
  output axi_reqrsp_pkg::w_chan_t    w_beat_o,
  output logic                       beat_valid_o,
  input  logic                       beat_ready_i,
  output logic                       in_burst_o
);

  import axi_reqrsp_pkg::*;

  len_t       cnt_d, cnt_q;
  beat_meta_t meta_d, meta_q;

  assign in_burst_o = (cnt_q != '0);

  always_comb begin
    aw_ready_o   = 1'b0;
    w_ready_o    = 1'b0;
    beat_o       = '0;
    w_beat_o     = '0;
    beat_valid_o = 1'b0;
    cnt_d        = cnt_q;
    meta_d       = meta_q;
    if (in_burst_o) begin
      beat_o      = meta_q;
      beat_o.addr = meta_q.addr + beat_bytes(meta_q.size);
      beat_o.last = (cnt_q == len_t'(1));
      // Each beat waits for its W data.
      if (w_valid_i) begin
        w_beat_o     = w_i;
        beat_valid_o = 1'b1;
        if (beat_ready_i) begin
          w_ready_o   = 1'b1;
          cnt_d       = cnt_q - len_t'(1);
          meta_d.addr = beat_o.addr;
        end
      end
    end else if (aw_valid_i && w_valid_i) begin
      meta_d = '{
        addr:  align_addr(aw_i.addr, aw_i.size),
        id:    aw_i.id,
        last:  (aw_i.len == '0),
        size:  aw_i.size,
        qos:   aw_i.qos,
        write: 1'b1
      };
      beat_o       = meta_d;
      beat_o.addr  = aw_i.addr;
      w_beat_o     = w_i;
      beat_valid_o = 1'b1;
      if (beat_ready_i) begin
        cnt_d      = aw_i.len;
        aw_ready_o = 1'b1;
        w_ready_o  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    meta_q <= meta_d;
  end

endmodule

//--- tests/axi_to_reqrsp_sva.sv
// ***************************************************************************
// Bridge protocol assertions
// ***************************************************************************
`timescale 1ns/1ps

module axi_to_reqrsp_sva (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic                     busy_o,
  input axi_reqrsp_pkg::ax_chan_t ar_i,
  input logic                     ar_valid_i,
  input logic                     ar_ready_o,
  input axi_reqrsp_pkg::ax_chan_t aw_i,
  input logic                     aw_valid_i,
  input logic                     aw_ready_o,
  input axi_reqrsp_pkg::w_chan_t  w_i,
  input logic                     w_valid_i,
  input logic                     w_ready_o,
  input axi_reqrsp_pkg::r_chan_t  r_o,
  input logic                     r_valid_o,
  input logic                     r_ready_i,
  input axi_reqrsp_pkg::mem_req_t mem_req_o,
  input logic                     mem_req_valid_o,
  input logic                     mem_req_ready_i
);

  ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_i))
    else $error("AR payload changed before its handshake");

  w_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    w_valid_i && !w_ready_o |=> w_valid_i && $stable(w_i))
    else $error("W payload changed before its handshake");

  // A stalled memory request must keep its arbitration choice.
  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else $error("Memory request changed while stalled");

  r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R beat changed while stalled");

  read_silent: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o && !mem_req_o.write |-> mem_req_o.data == '0 && mem_req_o.strb == '0)
    else $error("Read request carries data or strobe");

  // A burst of more than one beat keeps the bridge busy after its address handshake.
  busy_in_burst: assert property (@(posedge clk_i) disable iff (rst_i)
    (ar_valid_i && ar_ready_o && ar_i.len != '0) ||
    (aw_valid_i && aw_ready_o && aw_i.len != '0) |=> busy_o)
    else $error("Bridge reports idle while a burst is still running");

endmodule

bind axi_to_reqrsp axi_to_reqrsp_sva i_sva (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .busy_o          (busy_o),
  .ar_i            (ar_i),
  .ar_valid_i      (ar_valid_i),
  .ar_ready_o      (ar_ready_o),
  .aw_i            (aw_i),
  .aw_valid_i      (aw_valid_i),
  .aw_ready_o      (aw_ready_o),
  .w_i             (w_i),
  .w_valid_i       (w_valid_i),
  .w_ready_o       (w_ready_o),
  .r_o             (r_o),
  .r_valid_o       (r_valid_o),
  .r_ready_i       (r_ready_i),
  .mem_req_o       (mem_req_o),
  .mem_req_valid_o (mem_req_valid_o),
  .mem_req_ready_i (mem_req_ready_i)
);

//--- tests/tb_axi_to_reqrsp.sv
// ***************************************************************************
// AXI to reqrsp bridge testbench
// ***************************************************************************
`timescale 1ns/1ps

module tb_axi_to_reqrsp;

  import axi_reqrsp_pkg::*;

  localparam int WaitLimit = 2000;

  logic     clk, rst, busy;
  ax_chan_t ar = '0;
  ax_chan_t aw = '0;
  w_chan_t  w = '0;
  logic     ar_valid = 1'b0;
  logic     aw_valid = 1'b0;
  logic     w_valid = 1'b0;
  logic     r_ready = 1'b1;
  logic     b_ready = 1'b1;
  logic     mem_req_ready = 1'b1;
  mem_rsp_t mem_rsp = '0;
  logic     mem_rsp_valid = 1'b0;
  logic     ar_ready, aw_ready, w_ready, r_valid, b_valid;
  logic     mem_req_valid, mem_rsp_ready;
  r_chan_t  r_beat;
  b_chan_t  b_rsp;
  mem_req_t mem_req;

  int       seed = 36;
  int       delay = 0;
  logic     bp_en = 1'b0;
  string    test_name = "reset";
  data_t    mem [256];
  data_t    ref_mem [256];
  mem_rsp_t rsp_q [$];
  mem_req_t exp_rd_req [$];
  mem_req_t exp_wr_req [$];
  r_chan_t  exp_r [$];
  b_chan_t  exp_b [$];

  tb_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  axi_to_reqrsp #(
    .BufDepth (2)
  ) dut (
    .clk_i (clk), .rst_i (rst), .busy_o (busy),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .r_o (r_beat), .r_valid_o (r_valid), .r_ready_i (r_ready),
    .b_o (b_rsp), .b_valid_o (b_valid), .b_ready_i (b_ready),
    .mem_req_o (mem_req), .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_i (mem_rsp), .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready)
  );

  task automatic die(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_val(logic [127:0] expected, logic [127:0] actual);
    assert (expected === actual) else begin
      die($sformatf("Fail %s: expected %h, actual %h", test_name, expected, actual));
    end
  endtask

  function automatic logic in_err(addr_t a);
    return (a >= 32'h0000_0F00) && (a <= 32'h0000_0FFF);
  endfunction

  // Address of beat k. The first beat keeps the unaligned address.
  function automatic addr_t beat_addr(addr_t a, size_t s, int k);
    addr_t step;
    step = addr_t'(1) << s;
    if (k == 0) begin
      return a;
    end
    return (a & ~(step - addr_t'(1))) + addr_t'(k) * step;
  endfunction

  task automatic read_burst(id_t id, addr_t a, len_t len, size_t size, qos_t qos);
    addr_t ba;
    int    t;
    for (int k = 0; k <= int'(len); k++) begin
      ba = beat_addr(a, size, k);
      exp_rd_req.push_back('{addr: ba, write: 1'b0, data: '0, strb: '0, size: size});
      exp_r.push_back('{data: ref_mem[ba[9:2]], id: id, last: (len_t'(k) == len),
                        resp: in_err(ba) ? RespSlvErr : RespOkay});
    end
    @(posedge clk);
    ar       <= '{addr: a, id: id, len: len, size: size, qos: qos};
    ar_valid <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!ar_ready) begin
      t++;
      if (t > WaitLimit) die("AR handshake timed out");
      @(negedge clk);
    end
    @(posedge clk);
    ar_valid <= 1'b0;
  endtask

  task automatic write_burst(id_t id, addr_t a, len_t len, size_t size, qos_t qos,
                             strb_t strb);
    addr_t   ba;
    data_t   d;
    resp_t   last_resp;
    w_chan_t wq [$];
    int      t;
    last_resp = RespOkay;
    for (int k = 0; k <= int'(len); k++) begin
      ba = beat_addr(a, size, k);
      d  = 32'hC0DE_0000 ^ {id, 12'h0, ba[15:0]};
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) ref_mem[ba[9:2]][8*b +: 8] = d[8*b +: 8];
      end
      wq.push_back('{data: d, strb: strb});
      exp_wr_req.push_back('{addr: ba, write: 1'b1, data: d, strb: strb, size: size});
      last_resp = in_err(ba) ? RespSlvErr : RespOkay;
    end
    // Only the last beat's error reaches B.
    exp_b.push_back('{id: id, resp: last_resp});
    @(posedge clk);
    aw       <= '{addr: a, id: id, len: len, size: size, qos: qos};
    aw_valid <= 1'b1;
    for (int k = 0; k <= int'(len); k++) begin
      w       <= wq[k];
      w_valid <= 1'b1;
      t = 0;
      @(negedge clk);
      while (!w_ready) begin
        t++;
        if (t > WaitLimit) die("W handshake timed out");
        @(negedge clk);
      end
      // The first W beat goes together with the AW handshake.
      if (k == 0) begin
        check_val(64'd1, 64'(aw_ready));
      end
      @(posedge clk);
      aw_valid <= 1'b0;
    end
    w_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_r.size() != 0 || exp_b.size() != 0) begin
      t++;
      if (t > WaitLimit) die("Responses did not drain in time");
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // Memory model with random delays and stalls, plus random R and B back-pressure.
  always @(posedge clk) begin
    mem_rsp_t rsp;
    addr_t    a;
    int       r;
    if (rst) begin
      mem_rsp_valid <= 1'b0;
      mem_req_ready <= 1'b1;
      r_ready       <= 1'b1;
      b_ready       <= 1'b1;
      rsp_q.delete();
      delay = 0;
    end else begin
      r = $random(seed);
      mem_req_ready <= (r[2:0] != 3'd0);
      r_ready       <= !bp_en || r[3] || r[4];
      b_ready       <= !bp_en || r[5] || r[6];
      if (mem_req_valid && mem_req_ready) begin
        a = mem_req.addr;
        if (mem_req.write) begin
          if (exp_wr_req.size() == 0) begin
            die("Memory got a write request that no burst asked for");
          end
          check_val(128'(exp_wr_req[0]), 128'(mem_req));
          void'(exp_wr_req.pop_front());
          for (int b = 0; b < 4; b++) begin
            if (mem_req.strb[b]) mem[a[9:2]][8*b +: 8] = mem_req.data[8*b +: 8];
          end
        end else begin
          if (exp_rd_req.size() == 0) begin
            die("Memory got a read request that no burst asked for");
          end
          check_val(128'(exp_rd_req[0]), 128'(mem_req));
          void'(exp_rd_req.pop_front());
        end
        rsp.data  = mem_req.write ? '0 : mem[a[9:2]];
        rsp.error = in_err(a);
        rsp_q.push_back(rsp);
      end
      if (mem_rsp_valid && mem_rsp_ready) begin
        void'(rsp_q.pop_front());
        mem_rsp_valid <= 1'b0;
        delay = r & 3;
      end else if (!mem_rsp_valid && rsp_q.size() != 0) begin
        if (delay == 0) begin
          mem_rsp       <= rsp_q[0];
          mem_rsp_valid <= 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

  // Outputs are stable at the falling edge and transfer at the next rise.
  always @(negedge clk) begin
    if (!rst && r_valid && r_ready) begin
      if (exp_r.size() == 0) die("An R beat arrived that no read asked for");
      check_val(64'(exp_r[0]), 64'(r_beat));
      void'(exp_r.pop_front());
    end
    if (!rst && b_valid && b_ready) begin
      if (exp_b.size() == 0) die("A B response arrived that no write asked for");
      check_val(64'(exp_b[0]), 64'(b_rsp));
      void'(exp_b.pop_front());
    end
  end

  initial begin
    int t;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 32'h9E37_79B9 * (i + 1);
      ref_mem[i] = mem[i];
    end
    t = 0;
    @(negedge clk);
    while (rst) begin
      t++;
      if (t > WaitLimit) die("Reset never deasserted");
      @(negedge clk);
    end

    test_name = "read burst";
    read_burst(4'h1, 32'h104, 8'd3, 3'd2, 4'd0);
    read_burst(4'h2, 32'h203, 8'd3, 3'd1, 4'd0);
    wait_drain();

    test_name = "write burst";
    write_burst(4'h3, 32'h300, 8'd3, 3'd2, 4'd0, 4'hF);
    write_burst(4'h4, 32'h310, 8'd1, 3'd2, 4'd0, 4'b0101);
    wait_drain();
    read_burst(4'h5, 32'h300, 8'd7, 3'd2, 4'd0);
    wait_drain();

    test_name = "error mapping";
    read_burst(4'h6, 32'hEF8, 8'd3, 3'd2, 4'd0);
    write_burst(4'h7, 32'hFF8, 8'd1, 3'd2, 4'd0, 4'hF);
    wait_drain();

    test_name = "concurrent traffic";
    bp_en = 1'b1;
    fork
      for (int i = 0; i < 4; i++) begin
        read_burst(id_t'(8 + i), addr_t'(32 * i), 8'd5, 3'd2, 4'd0);
      end
      for (int i = 0; i < 3; i++) begin
        write_burst(id_t'(12 + i), addr_t'(32'h180 + 16 * i), 8'd3, 3'd2, 4'd0, 4'hF);
      end
    join
    wait_drain();
    bp_en = 1'b0;

    test_name = "qos priority";
    fork
      read_burst(4'h1, 32'h040, 8'd1, 3'd2, 4'd1);
      write_burst(4'h2, 32'h1C0, 8'd1, 3'd2, 4'd5, 4'hF);
      begin
        @(posedge clk);
        @(negedge clk);
        check_val(64'd1, 64'(mem_req_valid && mem_req.write));
      end
    join
    wait_drain();

    test_name = "busy";
    fork
      read_burst(4'h9, 32'h080, 8'd3, 3'd2, 4'd0);
      begin
        @(posedge clk);
        @(negedge clk);
        check_val(64'd1, 64'(busy));
      end
    join
    wait_drain();
    check_val(64'd0, 64'(busy));

    $display("Everything OK");
    $finish;
  end

endmodule

//--- tests/tb_clk_gen.sv
// ***************************************************************************
// Testbench clock and reset
// ***************************************************************************
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset is held for eight rising edges.
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- vlog.f
hw/axi_reqrsp_pkg.sv
hw/rd_burst_seq.sv
hw/wr_burst_seq.sv
hw/rw_arbiter.sv
hw/meta_fifo.sv
hw/req_issue.sv
hw/rsp_router.sv
hw/axi_to_reqrsp.sv
tests/tb_clk_gen.sv
tests/axi_to_reqrsp_sva.sv
tests/tb_axi_to_reqrsp.sv
